//--- Bender.yml
package:
  name: rv_core

export_include_dirs:
  - verilog

sources:
  - verilog/rv_core_pkg.sv
  - verilog/rv_decoder.sv
  - verilog/rv_regfile.sv
  - verilog/rv_alu.sv
  - verilog/rv_hazard_unit.sv
  - verilog/rv_pipe_reg.sv
  - verilog/rv_core.sv
  - target: test
    files:
      - tests/rv_core_properties.sv
      - tests/rv_core_tb.sv

//--- rv_core.f
+incdir+verilog
verilog/rv_core_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_hazard_unit.sv
verilog/rv_pipe_reg.sv
verilog/rv_core.sv
tests/rv_core_properties.sv
tests/rv_core_tb.sv

//--- tests/rv_core_properties.sv
`timescale 1ns/1ns

module rv_core_properties (
    input logic               clk,
    input logic               reset,
    input logic               mem_w,
    input logic               stall,
    input rv_core_pkg::word_t pc
);

    int fail_count = 0;

    mem_w_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(mem_w))
    else begin
        fail_count++;
        $error("mem_w is unknown");
    end

    // Load-use costs exactly one cycle
    stall_one_cycle: assert property (@(posedge clk) disable iff (reset) stall |=> !stall)
    else begin
        fail_count++;
        $error("stall held for two consecutive cycles");
    end

    pc_held: assert property (@(posedge clk) disable iff (reset) stall |=> $stable(pc))
    else begin
        fail_count++;
        $error("PC moved during a stall cycle");
    end

endmodule

bind rv_core rv_core_properties u_props (
    .clk(clk), .reset(reset), .mem_w(mem_w), .stall(stall), .pc(pc)
);

//--- tests/rv_core_tb.sv
`include "rv_core_config.svh"
`timescale 1ns/1ns

module rv_core_tb;

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;

    // funct3 per random op: add sub and or xor slt sll srl, then addi slti xori ori andi
    localparam logic [23:0] R_F3 = {3'd5, 3'd1, 3'd2, 3'd4, 3'd6, 3'd7, 3'd0, 3'd0};
    localparam logic [14:0] I_F3 = {3'd7, 3'd6, 3'd4, 3'd2, 3'd0};

    logic        clk = 1'b0;
    logic        reset;
    logic [4:0]  reg_sel;
    logic [31:0] inst_in;
    logic [31:0] data_in;
    logic [31:0] pc_out;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [31:0] reg_data;
    logic        mem_w;

    logic [31:0] imem [256];
    logic [31:0] dmem [64];
    logic [31:0] ref_mem [64];
    logic [31:0] exp_regs [32];
    logic [31:0] st_addr [$];
    logic [31:0] st_data [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    logic [31:0] lfsr = 32'h79eeb7ec;
    int          prog_len = 0;
    logic        prog_ready = 1'b0;
    int          checks = 0;
    int          errors = 0;

    always #5 clk = ~clk;

    rv_core uut (
        .clk(clk), .reset(reset), .inst_in(inst_in), .data_in(data_in), .reg_sel(reg_sel),
        .pc_out(pc_out), .data_addr(data_addr), .data_wdata(data_wdata), .mem_w(mem_w),
        .reg_data(reg_data)
    );

    // Same-cycle memories
    assign inst_in = imem[pc_out[9:2]];
    assign data_in = dmem[data_addr[7:2]];

    always @(posedge clk) begin
        if (mem_w === 1'b1) begin
            dmem[data_addr[7:2]] <= data_wdata;
            st_addr.push_back(data_addr);
            st_data.push_back(data_wdata);
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] dmem_fill(input int i);
        return (32'(i) * 32'h9e37_79b9) ^ 32'h00c0_ffee;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    // One random ALU op over x0..x7, so neighbours depend on each other
    task automatic add_random_alu();
        int         k;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        k   = int'(rand_bits(4) % 13);
        rd  = 5'(rand_bits(3));
        rs1 = 5'(rand_bits(3));
        rs2 = 5'(rand_bits(3));
        if (k < 8) begin
            emit(enc_r((k == 1) ? 7'h20 : 7'h00, rs2, rs1, R_F3[k*3 +: 3], rd));
        end else begin
            emit(enc_i(12'(rand_bits(12)), rs1, I_F3[(k-8)*3 +: 3], rd, OPC_OP_IMM));
        end
    endtask

    task automatic build_program();
        logic [11:0] off_a;
        logic [11:0] off_b;
        logic [12:0] br_off;
        logic [4:0]  br_rs2;
        logic [2:0]  br_f3;
        for (int i = 0; i < 256; i++) begin
            imem[i] = `RV_NOP;
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] = dmem_fill(i);
        end
        for (int i = 0; i < 40; i++) begin
            add_random_alu();
        end
        for (int i = 0; i < 6; i++) begin
            off_a = 12'(rand_bits(4) << 2);
            off_b = rand_bits(1) ? off_a : 12'(rand_bits(4) << 2);  // Often the same word
            emit(enc_i(12'(rand_bits(12)), 5'd2, 3'd0, 5'd5, OPC_OP_IMM));
            emit(enc_s(off_a, 5'd5, 5'd0));                  // Data from the addi just before
            emit(enc_i(off_b, 5'd0, 3'd2, 5'd6, OPC_LOAD));
            emit(enc_r(7'h00, 5'd5, 5'd6, 3'd0, 5'd7));      // Load-use
            emit(enc_i(off_a ^ 12'd4, 5'd0, 3'd2, 5'd3, OPC_LOAD));
            emit(enc_s(off_b, 5'd3, 5'd0));
        end
        // Branches on a value computed one instruction earlier
        for (int i = 0; i < 8; i++) begin
            br_off = rand_bits(1) ? 13'd12 : 13'd8;
            br_rs2 = rand_bits(1) ? 5'd1 : 5'd3;
            br_f3  = 3'(rand_bits(1));
            emit(enc_i(12'(rand_bits(3)), 5'd2, 3'd0, 5'd1, OPC_OP_IMM));
            emit(enc_b(br_off, br_rs2, 5'd1, br_f3));
            emit(enc_i(12'd1, 5'd4, 3'd0, 5'd4, OPC_OP_IMM));  // Shadow slots
            emit(enc_i(12'd1, 5'd5, 3'd0, 5'd5, OPC_OP_IMM));
        end
        for (int i = 0; i < 3; i++) begin
            emit(enc_i(12'(rand_bits(4) << 2), 5'd0, 3'd2, 5'd6, OPC_LOAD));
            emit(enc_b(13'd8, 5'd5, 5'd6, 3'd1));             // bne on fresh load data
            emit(enc_i(12'd1, 5'd7, 3'd0, 5'd7, OPC_OP_IMM));
        end
        emit(enc_b(13'd0, 5'd0, 5'd0, 3'd0));                 // beq x0, x0, 0
        prog_ready = 1'b1;
    endtask

    // ISA-level model; fills exp_regs and the expected store log
    function automatic void rv_ref_run();
        logic [31:0] pc;
        logic [31:0] next;
        logic [31:0] halt;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic        wr;
        int          steps;
        for (int r = 0; r < 32; r++) begin
            exp_regs[r] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            ref_mem[i] = dmem_fill(i);
        end
        exp_addr.delete();
        exp_data.delete();
        pc   = `RV_RESET_PC;
        halt = 32'(4 * (prog_len - 1));
        for (steps = 0; steps < 10000 && pc != halt; steps++) begin
            inst  = imem[pc[9:2]];
            a     = exp_regs[inst[19:15]];
            b     = exp_regs[inst[24:20]];
            imm_i = {{20{inst[31]}}, inst[31:20]};
            imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            wr    = 1'b1;
            res   = '0;
            next  = pc + 32'd4;
            case (inst[6:0])
                7'b0110011: begin
                    case (inst[14:12])
                        3'd0:    res = inst[30] ? a - b : a + b;
                        3'd1:    res = a << b[4:0];
                        3'd2:    res = 32'($signed(a) < $signed(b));
                        3'd4:    res = a ^ b;
                        3'd5:    res = a >> b[4:0];
                        3'd6:    res = a | b;
                        3'd7:    res = a & b;
                        default: wr = 1'b0;
                    endcase
                end
                7'b0010011: begin
                    case (inst[14:12])
                        3'd0:    res = a + imm_i;
                        3'd2:    res = 32'($signed(a) < $signed(imm_i));
                        3'd4:    res = a ^ imm_i;
                        3'd6:    res = a | imm_i;
                        3'd7:    res = a & imm_i;
                        default: wr = 1'b0;
                    endcase
                end
                7'b0000011: begin  // lw
                    addr = a + imm_i;
                    res  = ref_mem[addr[7:2]];
                end
                7'b0100011: begin  // sw
                    addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                    ref_mem[addr[7:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                    wr = 1'b0;
                end
                7'b1100011: begin
                    wr = 1'b0;
                    if ((a == b) != inst[12]) begin  // funct3 bit 0 selects bne
                        next = pc + imm_b;
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && inst[11:7] != 5'd0) begin
                exp_regs[inst[11:7]] = res;
            end
            pc = next;
        end
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_results();
        int n;
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            #1 reg_sel = 5'(r);
            @(negedge clk);
            check_value($sformatf("x%0d", r), reg_data, exp_regs[r]);
        end
        check_value("store count", 32'(st_addr.size()), 32'(exp_addr.size()));
        n = (st_addr.size() < exp_addr.size()) ? st_addr.size() : exp_addr.size();
        for (int i = 0; i < n; i++) begin
            check_value($sformatf("store %0d address", i), st_addr[i], exp_addr[i]);
            check_value($sformatf("store %0d data", i), st_data[i], exp_data[i]);
        end
    endtask

    initial begin : main
        int stable;
        reset   = 1'b1;
        reg_sel = '0;
        build_program();
        rv_ref_run();
        repeat (9) @(posedge clk);
        @(negedge clk);
        check_value("pc_out in reset", pc_out, `RV_RESET_PC);
        check_value("mem_w in reset", 32'(mem_w), 32'd0);
        @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        check_value("pc_out after reset", pc_out, `RV_RESET_PC);
        check_value("mem_w after reset", 32'(mem_w), 32'd0);
        // Closing self-loop toggles between its address and the next
        stable = 0;
        while (stable < 8) begin
            @(negedge clk);
            stable = (pc_out >= 32'(4 * (prog_len - 1))) ? stable + 1 : 0;
        end
        compare_results();
        errors = errors + uut.u_props.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        wait (prog_ready);
        repeat (prog_len * 200) @(posedge clk);
        $display("Timeout: the core never settled in the closing loop");
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- verilog/rv_alu.sv
`timescale 1ns/1ns

module rv_alu (
    input  rv_core_pkg::alu_op_e op,
    input  rv_core_pkg::word_t   a,
    input  rv_core_pkg::word_t   b,
    output rv_core_pkg::word_t   result
);
    import rv_core_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = word_t'($signed(a) < $signed(b));
            ALU_SLL: result = a << shamt;
            ALU_SRL: result = a >> shamt;  // Logical, no sra
            default: result = a + b;
        endcase
    end

endmodule

//--- verilog/rv_core.sv
`include "rv_core_config.svh"
`timescale 1ns/1ns

module rv_core (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_core_pkg::word_t    inst_in,
    input  rv_core_pkg::word_t    data_in,
    input  rv_core_pkg::reg_idx_t reg_sel,
    output rv_core_pkg::word_t    pc_out,
    output rv_core_pkg::word_t    data_addr,
    output rv_core_pkg::word_t    data_wdata,
    output logic                  mem_w,
    output rv_core_pkg::word_t    reg_data
);
    import rv_core_pkg::*;

    word_t    pc;
    if_id_t   if_id_d, if_id_q;
    id_ex_t   id_ex_d, id_ex_q;
    ex_mem_t  ex_mem_d, ex_mem_q;
    mem_wb_t  mem_wb_d, mem_wb_q;

    word_t    inst_id, imm_id, rf_a, rf_b, br_a, br_b, br_target;
    reg_idx_t rs1_id, rs2_id, rd_id;
    ctrl_t    ctrl_id;
    logic     is_branch_id, branch_ne_id, branch_taken;

    word_t    op_a, op_b_reg, alu_b, alu_result;
    word_t    mem_fwd, wb_data;
    fwd_sel_e fwd_a, fwd_b, br_fwd_a, br_fwd_b;
    logic     stall, flush_if_id, bubble_id_ex;

    function automatic word_t fwd_pick(fwd_sel_e sel, word_t rf_val, word_t wb_val,
                                       word_t mem_val, word_t ex_val);
        case (sel)
            FWD_WB:  return wb_val;
            FWD_MEM: return mem_val;
            FWD_EX:  return ex_val;
            default: return rf_val;
        endcase
    endfunction

    // Fetch
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `RV_RESET_PC;
        end else if (!stall) begin
            pc <= flush_if_id ? br_target : pc + 32'd4;  // Taken branch redirects
        end
    end

    assign pc_out  = pc;
    assign if_id_d = '{valid: 1'b1, pc: pc, inst: inst_in};

    rv_pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk(clk), .reset(reset), .enable(!stall), .flush(flush_if_id),
        .d(if_id_d), .q(if_id_q)
    );

    // Decode
    assign inst_id = if_id_q.valid ? if_id_q.inst : `RV_NOP;  // Empty slot

    rv_decoder u_decoder (
        .inst(inst_id), .rs1(rs1_id), .rs2(rs2_id), .rd(rd_id), .imm(imm_id),
        .ctrl(ctrl_id), .is_branch(is_branch_id), .branch_ne(branch_ne_id)
    );

    rv_regfile u_regfile (
        .clk(clk), .reset(reset),
        .we(mem_wb_q.valid && mem_wb_q.reg_write), .waddr(mem_wb_q.rd), .wdata(wb_data),
        .raddr_a(rs1_id), .raddr_b(rs2_id), .rdata_a(rf_a), .rdata_b(rf_b),
        .dbg_sel(reg_sel), .dbg_data(reg_data)
    );

    assign br_a         = fwd_pick(br_fwd_a, rf_a, wb_data, mem_fwd, alu_result);
    assign br_b         = fwd_pick(br_fwd_b, rf_b, wb_data, mem_fwd, alu_result);
    assign branch_taken = (br_a == br_b) ^ branch_ne_id;
    assign br_target    = if_id_q.pc + imm_id;

    // Value retiring this cycle is gone by the time decode reaches execute
    always_comb begin
        id_ex_d          = '0;
        id_ex_d.valid    = if_id_q.valid;
        id_ex_d.pc       = if_id_q.pc;
        id_ex_d.rs1_data = (br_fwd_a == FWD_WB) ? wb_data : rf_a;
        id_ex_d.rs2_data = (br_fwd_b == FWD_WB) ? wb_data : rf_b;
        id_ex_d.imm      = imm_id;
        id_ex_d.rs1      = rs1_id;
        id_ex_d.rs2      = rs2_id;
        id_ex_d.rd       = rd_id;
        id_ex_d.ctrl     = ctrl_id;
    end

    rv_pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk(clk), .reset(reset), .enable(1'b1), .flush(bubble_id_ex),
        .d(id_ex_d), .q(id_ex_q)
    );

    // Execute operands forward from memory and writeback only
    assign op_a     = (fwd_a == FWD_MEM) ? mem_fwd :
                      (fwd_a == FWD_WB)  ? wb_data : id_ex_q.rs1_data;
    assign op_b_reg = (fwd_b == FWD_MEM) ? mem_fwd :
                      (fwd_b == FWD_WB)  ? wb_data : id_ex_q.rs2_data;
    assign alu_b    = id_ex_q.ctrl.alu_src_imm ? id_ex_q.imm : op_b_reg;

    rv_alu u_alu (
        .op(id_ex_q.ctrl.alu_op), .a(op_a), .b(alu_b), .result(alu_result)
    );

    assign ex_mem_d = '{valid: id_ex_q.valid, alu_result: alu_result,
                        store_data: op_b_reg, rd: id_ex_q.rd, ctrl: id_ex_q.ctrl};

    rv_pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk(clk), .reset(reset), .enable(1'b1), .flush(1'b0),
        .d(ex_mem_d), .q(ex_mem_q)
    );

    // Memory
    assign data_addr  = ex_mem_q.alu_result;
    assign data_wdata = ex_mem_q.store_data;
    assign mem_w      = ex_mem_q.valid && ex_mem_q.ctrl.mem_write;
    assign mem_fwd    = ex_mem_q.ctrl.mem_read ? data_in : ex_mem_q.alu_result;

    assign mem_wb_d = '{valid: ex_mem_q.valid, alu_result: ex_mem_q.alu_result,
                        load_data: data_in, rd: ex_mem_q.rd,
                        reg_write: ex_mem_q.ctrl.reg_write, wb_sel: ex_mem_q.ctrl.wb_sel};

    rv_pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk(clk), .reset(reset), .enable(1'b1), .flush(1'b0),
        .d(mem_wb_d), .q(mem_wb_q)
    );

    // Writeback
    assign wb_data = (mem_wb_q.wb_sel == WB_MEM) ? mem_wb_q.load_data : mem_wb_q.alu_result;

    rv_hazard_unit u_hazard (
        .rs1_id(rs1_id), .rs2_id(rs2_id),
        .is_branch_id(is_branch_id), .branch_taken(branch_taken),
        .rs1_ex(id_ex_q.rs1), .rs2_ex(id_ex_q.rs2), .rd_ex(id_ex_q.rd),
        .reg_write_ex(id_ex_q.valid && id_ex_q.ctrl.reg_write),
        .mem_read_ex(id_ex_q.ctrl.mem_read),
        .rd_mem(ex_mem_q.rd), .reg_write_mem(ex_mem_q.valid && ex_mem_q.ctrl.reg_write),
        .rd_wb(mem_wb_q.rd), .reg_write_wb(mem_wb_q.valid && mem_wb_q.reg_write),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .br_fwd_a(br_fwd_a), .br_fwd_b(br_fwd_b),
        .stall(stall), .flush_if_id(flush_if_id), .bubble_id_ex(bubble_id_ex)
    );

endmodule

//--- verilog/rv_core_config.svh
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// Data and address width
`define RV_XLEN 32

// Architectural register count
`define RV_NREGS 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

//--- verilog/rv_core_pkg.sv
`include "rv_core_config.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0]         word_t;
    typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    typedef enum logic {
        WB_ALU,
        WB_MEM
    } wb_sel_e;

    // Operand source, ordered as in the forwarding muxes
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_WB,
        FWD_MEM,
        FWD_EX
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;  // Operand b from immediate
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        wb_sel_e wb_sel;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    imm;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        ctrl_t    ctrl;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    alu_result;  // Also the data address
        word_t    store_data;
        reg_idx_t rd;
        ctrl_t    ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        word_t    alu_result;
        word_t    load_data;
        reg_idx_t rd;
        logic     reg_write;
        wb_sel_e  wb_sel;
    } mem_wb_t;

endpackage

//--- verilog/rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder (
    input  rv_core_pkg::word_t    inst,
    output rv_core_pkg::reg_idx_t rs1,
    output rv_core_pkg::reg_idx_t rs2,
    output rv_core_pkg::reg_idx_t rd,
    output rv_core_pkg::word_t    imm,
    output rv_core_pkg::ctrl_t    ctrl,
    output logic                  is_branch,
    output logic                  branch_ne
);
    import rv_core_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       use_rs1;
    logic       use_rs2;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // Unused source fields read as x0 so they never raise a false hazard
    assign rs1 = use_rs1 ? inst[19:15] : '0;
    assign rs2 = use_rs2 ? inst[24:20] : '0;
    assign rd  = inst[11:7];

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        ctrl.wb_sel = WB_ALU;
        is_branch   = 1'b0;
        branch_ne   = 1'b0;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        imm         = {{20{inst[31]}}, inst[31:20]};  // I form
        case (opcode)
            OPC_OP: begin
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
                ctrl.reg_write = (funct7 == 7'b0000000);
                case (funct3)
                    3'b000: begin
                        ctrl.alu_op    = funct7[5] ? ALU_SUB : ALU_ADD;
                        ctrl.reg_write = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                    end
                    3'b001:  ctrl.alu_op = ALU_SLL;
                    3'b010:  ctrl.alu_op = ALU_SLT;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b101:  ctrl.alu_op = ALU_SRL;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    default: ctrl.reg_write = 1'b0;  // sltu
                endcase
            end
            OPC_OP_IMM: begin
                use_rs1          = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = ALU_ADD;
                    3'b010:  ctrl.alu_op = ALU_SLT;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    default: ctrl.reg_write = 1'b0;  // Immediate shifts, sltiu
                endcase
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin      // lw only
                    use_rs1          = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.reg_write   = 1'b1;
                    ctrl.mem_read    = 1'b1;
                    ctrl.wb_sel      = WB_MEM;
                end
            end
            OPC_STORE: begin
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                if (funct3 == 3'b010) begin      // sw only
                    use_rs1          = 1'b1;
                    use_rs2          = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.mem_write   = 1'b1;
                end
            end
            OPC_BRANCH: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                if (funct3[2:1] == 2'b00) begin  // beq, bne
                    use_rs1   = 1'b1;
                    use_rs2   = 1'b1;
                    is_branch = 1'b1;
                    branch_ne = funct3[0];
                end
            end
            default: ;  // Anything else is a no-op
        endcase
    end

endmodule

//--- verilog/rv_hazard_unit.sv
`timescale 1ns/1ns

module rv_hazard_unit (
    input  rv_core_pkg::reg_idx_t rs1_id,
    input  rv_core_pkg::reg_idx_t rs2_id,
    input  logic                  is_branch_id,
    input  logic                  branch_taken,
    input  rv_core_pkg::reg_idx_t rs1_ex,
    input  rv_core_pkg::reg_idx_t rs2_ex,
    input  rv_core_pkg::reg_idx_t rd_ex,
    input  logic                  reg_write_ex,
    input  logic                  mem_read_ex,
    input  rv_core_pkg::reg_idx_t rd_mem,
    input  logic                  reg_write_mem,
    input  rv_core_pkg::reg_idx_t rd_wb,
    input  logic                  reg_write_wb,
    output rv_core_pkg::fwd_sel_e fwd_a,
    output rv_core_pkg::fwd_sel_e fwd_b,
    output rv_core_pkg::fwd_sel_e br_fwd_a,
    output rv_core_pkg::fwd_sel_e br_fwd_b,
    output logic                  stall,
    output logic                  flush_if_id,
    output logic                  bubble_id_ex
);
    import rv_core_pkg::*;

    // Producer writes the register a consumer reads; x0 never matches
    function automatic logic hit(reg_idx_t rd, logic we, reg_idx_t rs);
        return we && (rd != '0) && (rd == rs);
    endfunction

    // Execute operands, newest producer first
    function automatic fwd_sel_e ex_pick(reg_idx_t rs);
        if (hit(rd_mem, reg_write_mem, rs)) return FWD_MEM;
        if (hit(rd_wb, reg_write_wb, rs))   return FWD_WB;
        return FWD_RF;
    endfunction

    // Decode operands also see the instruction in execute
    function automatic fwd_sel_e id_pick(reg_idx_t rs);
        if (hit(rd_ex, reg_write_ex, rs)) return FWD_EX;
        return ex_pick(rs);
    endfunction

    assign fwd_a    = ex_pick(rs1_ex);
    assign fwd_b    = ex_pick(rs2_ex);
    assign br_fwd_a = id_pick(rs1_id);
    assign br_fwd_b = id_pick(rs2_id);

    // Load data is not ready until the memory stage
    assign stall = mem_read_ex &&
                   (hit(rd_ex, reg_write_ex, rs1_id) || hit(rd_ex, reg_write_ex, rs2_id));

    assign flush_if_id  = is_branch_id && branch_taken && !stall;
    assign bubble_id_ex = stall;

endmodule

//--- verilog/rv_pipe_reg.sv
`timescale 1ns/1ns

module rv_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     enable,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // All-zero payload is an invalid slot
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (enable) begin
            q <= d;
        end
    end

endmodule

//--- verilog/rv_regfile.sv
`include "rv_core_config.svh"
`timescale 1ns/1ns

module rv_regfile (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  rv_core_pkg::reg_idx_t waddr,
    input  rv_core_pkg::word_t    wdata,
    input  rv_core_pkg::reg_idx_t raddr_a,
    input  rv_core_pkg::reg_idx_t raddr_b,
    output rv_core_pkg::word_t    rdata_a,
    output rv_core_pkg::word_t    rdata_b,
    input  rv_core_pkg::reg_idx_t dbg_sel,
    output rv_core_pkg::word_t    dbg_data
);
    import rv_core_pkg::*;

    word_t regs [`RV_NREGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin  // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a  = regs[raddr_a];
    assign rdata_b  = regs[raddr_b];
    assign dbg_data = (dbg_sel == '0) ? '0 : regs[dbg_sel];

endmodule
